// ==== motorDrive.f ====
motorDrivePkg.sv
periodControl.sv
stepSequencer.sv
phaseDriver.sv
motorDrive.sv
motorDrive_properties.sv
tbMotorDrive.sv

// ==== motorDrive.sv ====
module motorDrive import motorDrivePkg::*; #(
    parameter int unsigned counterWidth = 25,
    parameter int unsigned minPeriod = 2,
    parameter int unsigned maxPeriod = 20000000,
    parameter int unsigned initPeriod = 1000000,
    parameter int unsigned periodDelta = 1000,
    parameter int unsigned revWidth = 32
) (
    input  logic                clk,
    input  logic                arstN,
    input  logic                start,
    input  logic                freqInc,
    input  logic                freqDec,
    output driveOut_t           gates,
    output logic                stepStrobe,
    output logic [revWidth-1:0] revCount
);

    logic [counterWidth-1:0] reloadPeriod;
    phaseSteps_t             steps;
    logic                    running;

    periodControl #(
        .counterWidth (counterWidth),
        .minPeriod    (minPeriod),
        .maxPeriod    (maxPeriod),
        .initPeriod   (initPeriod),
        .periodDelta  (periodDelta)
    ) uPeriodControl (
        .clk          (clk),
        .arstN        (arstN),
        .freqInc      (freqInc),
        .freqDec      (freqDec),
        .reloadPeriod (reloadPeriod)
    );

    stepSequencer #(
        .counterWidth (counterWidth),
        .revWidth     (revWidth)
    ) uStepSequencer (
        .clk          (clk),
        .arstN        (arstN),
        .start        (start),
        .reloadPeriod (reloadPeriod),
        .steps        (steps),
        .running      (running),
        .stepStrobe   (stepStrobe),
        .revCount     (revCount)
    );

    phaseDriver uPhaseDriver (
        .clk     (clk),
        .arstN   (arstN),
        .steps   (steps),
        .running (running),
        .gates   (gates)
    );

endmodule

// ==== motorDrivePkg.sv ====
package motorDrivePkg;

    //////////////////////////////////////////////////
    // step sequence constants
    //////////////////////////////////////////////////

    localparam int unsigned stepsPerCycle = 12; // steps in one electrical cycle.
    localparam int unsigned phaseOffset = 4; // a third of a cycle between phases.

    // 4-bit step index: 0 idle, 1..12 sequence steps, 15 invalid.
    typedef logic [3:0] stepIdx_t;

    localparam stepIdx_t stepIdle = 4'd0;
    localparam stepIdx_t stepFirst = 4'd1;
    localparam stepIdx_t stepInvalid = 4'hF;

    //////////////////////////////////////////////////
    // per-phase bundles
    //////////////////////////////////////////////////

    typedef struct packed {
        stepIdx_t stepA;
        stepIdx_t stepB;
        stepIdx_t stepC;
    } phaseSteps_t;

    typedef struct packed {
        logic high; // high-side switch enable.
        logic low; // low-side switch enable.
    } phaseGate_t;

    typedef struct packed {
        phaseGate_t phaseA;
        phaseGate_t phaseB;
        phaseGate_t phaseC;
    } driveOut_t;

    // sequencer run state.
    typedef enum logic {
        SEQ_IDLE = 1'b0,
        SEQ_RUN  = 1'b1
    } seqState_t;

endpackage

// ==== motorDrive_properties.sv ====
module motorDriveProperties import motorDrivePkg::*; (
    input logic        clk,
    input logic        arstN,
    input logic        start,
    input driveOut_t   gates,
    input phaseSteps_t steps
);

    int failCount = 0; // read by the testbench after each cycle.

    //////////////////////////////////////////////////
    // gate safety
    //////////////////////////////////////////////////

    aNoShootA: assert property (@(posedge clk) disable iff (!arstN)
        !(gates.phaseA.high && gates.phaseA.low))
    else begin
        $error("phase A has high and low enabled together");
        failCount++;
    end

    aNoShootB: assert property (@(posedge clk) disable iff (!arstN)
        !(gates.phaseB.high && gates.phaseB.low))
    else begin
        $error("phase B has high and low enabled together");
        failCount++;
    end

    aNoShootC: assert property (@(posedge clk) disable iff (!arstN)
        !(gates.phaseC.high && gates.phaseC.low))
    else begin
        $error("phase C has high and low enabled together");
        failCount++;
    end

    // a stopped motor releases every switch on the following edge.
    aOffWhenStopped: assert property (@(posedge clk) disable iff (!arstN)
        !start |=> (gates == '0))
    else begin
        $error("gates still on one cycle after start went low");
        failCount++;
    end

    //////////////////////////////////////////////////
    // step index range
    //////////////////////////////////////////////////

    aStepRange: assert property (@(posedge clk) disable iff (!arstN)
        (steps.stepA <= stepsPerCycle) && (steps.stepB <= stepsPerCycle)
        && (steps.stepC <= stepsPerCycle))
    else begin
        $error("a step index left the range 0 to 12");
        failCount++;
    end

endmodule

bind motorDrive motorDriveProperties uProps (
    .clk   (clk),
    .arstN (arstN),
    .start (start),
    .gates (gates),
    .steps (steps)
);

// ==== periodControl.sv ====
module periodControl #(
    parameter int unsigned counterWidth = 25,
    parameter int unsigned minPeriod = 2,
    parameter int unsigned maxPeriod = 20000000,
    parameter int unsigned initPeriod = 1000000,
    parameter int unsigned periodDelta = 1000
) (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    freqInc,
    input  logic                    freqDec,
    output logic [counterWidth-1:0] reloadPeriod
);

    //////////////////////////////////////////////////
    // limits in counter width
    //////////////////////////////////////////////////

    localparam logic [counterWidth-1:0] minValue = counterWidth'(minPeriod);
    localparam logic [counterWidth-1:0] maxValue = counterWidth'(maxPeriod);
    localparam logic [counterWidth-1:0] initValue = counterWidth'(initPeriod);
    localparam logic [counterWidth-1:0] deltaValue = counterWidth'(periodDelta);

    // thresholds where a full step would cross a limit.
    localparam logic [counterWidth-1:0] decFloor = counterWidth'(minPeriod + periodDelta);
    localparam logic [counterWidth-1:0] incCeiling =
        (maxPeriod > periodDelta) ? counterWidth'(maxPeriod - periodDelta) : '0;

    logic                    doInc;
    logic                    doDec;
    logic [counterWidth-1:0] nextPeriod;

    assign doInc = freqInc && !freqDec; // both together cancel out.
    assign doDec = freqDec && !freqInc;

    //////////////////////////////////////////////////
    // saturating update
    //////////////////////////////////////////////////

    always_comb begin
        nextPeriod = reloadPeriod;
        if (doInc) begin
            // a higher frequency means a shorter step period.
            if (reloadPeriod >= decFloor) begin
                nextPeriod = reloadPeriod - deltaValue;
            end else begin
                nextPeriod = minValue;
            end
        end else if (doDec) begin
            if (reloadPeriod <= incCeiling) begin
                nextPeriod = reloadPeriod + deltaValue;
            end else begin
                nextPeriod = maxValue;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            reloadPeriod <= initValue;
        end else begin
            reloadPeriod <= nextPeriod;
        end
    end

endmodule

// ==== phaseDriver.sv ====
module phaseDriver import motorDrivePkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  phaseSteps_t steps,
    input  logic        running,
    output driveOut_t   gates
);

    //////////////////////////////////////////////////
    // step index to gate pattern
    //////////////////////////////////////////////////

    // first third of the cycle drives high, the opposite third drives low.
    function automatic phaseGate_t gateFor(stepIdx_t idx);
        phaseGate_t gate;
        gate = '0;
        case (idx)
            4'd1, 4'd2, 4'd3, 4'd4: begin
                gate.high = 1'b1;
            end
            4'd7, 4'd8, 4'd9, 4'd10: begin
                gate.low = 1'b1;
            end
            default: begin
                gate = '0; // float, idle and invalid all leave both off.
            end
        endcase
        return gate;
    endfunction

    driveOut_t nextGates;

    always_comb begin
        nextGates = '0;
        if (running) begin
            nextGates.phaseA = gateFor(steps.stepA);
            nextGates.phaseB = gateFor(steps.stepB);
            nextGates.phaseC = gateFor(steps.stepC);
        end
    end

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            gates <= '0;
        end else begin
            gates <= nextGates; // one cycle behind the step index.
        end
    end

endmodule

// ==== stepSequencer.sv ====
module stepSequencer import motorDrivePkg::*; #(
    parameter int unsigned counterWidth = 25,
    parameter int unsigned revWidth = 32
) (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    start,
    input  logic [counterWidth-1:0] reloadPeriod,
    output phaseSteps_t             steps,
    output logic                    running,
    output logic                    stepStrobe,
    output logic [revWidth-1:0]     revCount
);

    // revolution is counted on the step out of the middle of the cycle.
    localparam stepIdx_t revStep = stepIdx_t'(stepsPerCycle / 2);
    localparam stepIdx_t lastStep = stepIdx_t'(stepsPerCycle);

    seqState_t               state;
    logic                    startQ;
    logic                    startUp;
    logic [counterWidth-1:0] count;
    logic                    lastCount;
    stepIdx_t                stepA;

    // shifts a phase-A index by a number of steps, staying in 1..12.
    function automatic stepIdx_t offsetStep(stepIdx_t idx, int unsigned shift);
        int unsigned pos;
        if (idx == stepIdle) begin
            return stepIdle;
        end
        if (idx > stepsPerCycle) begin
            return stepInvalid;
        end
        pos = (idx - 1 + shift) % stepsPerCycle;
        return stepIdx_t'(pos + 1);
    endfunction

    //////////////////////////////////////////////////
    // start edge and step timing
    //////////////////////////////////////////////////

    assign startUp = start && !startQ;
    assign running = (state == SEQ_RUN) && start; // drops in the cycle start falls.
    assign lastCount = (count == counterWidth'(1));
    assign stepStrobe = running && lastCount;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            startQ <= 1'b0;
        end else begin
            startQ <= start;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count <= '0;
        end else if (startUp || stepStrobe) begin
            count <= reloadPeriod; // each step keeps the period seen at its load.
        end else if (running) begin
            count <= count - 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // phase-A index and run state
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= SEQ_IDLE;
            stepA <= stepIdle;
        end else if (!start) begin
            state <= SEQ_IDLE;
            stepA <= stepIdle;
        end else if (startUp) begin
            state <= SEQ_RUN;
            stepA <= stepFirst;
        end else if (stepStrobe) begin
            if (stepA == lastStep) begin
                stepA <= stepFirst;
            end else begin
                stepA <= stepA + 1'b1;
            end
        end
    end

    always_comb begin
        steps.stepA = stepA;
        steps.stepB = offsetStep(stepA, 2 * phaseOffset);
        steps.stepC = offsetStep(stepA, phaseOffset);
    end

    //////////////////////////////////////////////////
    // revolution counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            revCount <= '0;
        end else if (!start) begin
            revCount <= '0;
        end else if (stepStrobe && (stepA == revStep)) begin
            revCount <= revCount + 1'b1;
        end
    end

endmodule

// ==== tbMotorDrive.sv ====
module tbMotorDrive import motorDrivePkg::*; ();

    localparam int counterWidth = 8;
    localparam int minPeriod = 2;
    localparam int maxPeriod = 9;
    localparam int initPeriod = 5;
    localparam int periodDelta = 2;
    localparam int revWidth = 16;

    logic                clk;
    logic                arstN;
    logic                start;
    logic                freqInc;
    logic                freqDec;
    driveOut_t           gates;
    logic                stepStrobe;
    logic [revWidth-1:0] revCount;

    integer seed;
    string  testName;
    logic   lastStrobe;

    // reference model state, updated once per rising edge.
    int                  mPeriod;
    int                  mStep;
    int                  mCount;
    logic [revWidth-1:0] mRev;
    logic                mRun;
    logic                mStartPrev;
    driveOut_t           mGates;

    motorDrive #(
        .counterWidth (counterWidth),
        .minPeriod    (minPeriod),
        .maxPeriod    (maxPeriod),
        .initPeriod   (initPeriod),
        .periodDelta  (periodDelta),
        .revWidth     (revWidth)
    ) dut (
        .clk        (clk),
        .arstN      (arstN),
        .start      (start),
        .freqInc    (freqInc),
        .freqDec    (freqDec),
        .gates      (gates),
        .stepStrobe (stepStrobe),
        .revCount   (revCount)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // failure reporting and compare tasks
    //////////////////////////////////////////////////

    task automatic failNow(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkGates(input string name, input driveOut_t expected,
                              input driveOut_t actual);
        logic [5:0] e;
        logic [5:0] a;
        e = expected;
        a = actual;
        if (e !== a) begin
            failNow($sformatf("CHECK FAILED %s gates expected %b actual %b", name, e, a));
        end
    endtask

    task automatic checkStrobe(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            failNow($sformatf("CHECK FAILED %s stepStrobe expected %b actual %b",
                name, expected, actual));
        end
    endtask

    task automatic checkRev(input string name, input logic [revWidth-1:0] expected,
                            input logic [revWidth-1:0] actual);
        if (expected !== actual) begin
            failNow($sformatf("CHECK FAILED %s revCount expected %0d actual %0d",
                name, expected, actual));
        end
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // another phase sits a fixed number of steps ahead of phase A.
    function automatic int shiftStep(int a, int ahead);
        if (a == 0) begin
            return 0;
        end
        return ((a - 1 + ahead) % 12) + 1;
    endfunction

    function automatic phaseGate_t expectedGate(int idx);
        phaseGate_t g;
        g.high = (idx >= 1) && (idx <= 4);
        g.low = (idx >= 7) && (idx <= 10);
        return g;
    endfunction

    function automatic driveOut_t expectedDrive(int a);
        driveOut_t d;
        d.phaseA = expectedGate(a);
        d.phaseB = expectedGate(shiftStep(a, 8));
        d.phaseC = expectedGate(shiftStep(a, 4));
        return d;
    endfunction

    task automatic advanceModel(input logic s, input logic inc, input logic dec);
        int nextPeriod;
        nextPeriod = mPeriod;
        mGates = (mRun && s) ? expectedDrive(mStep) : '0; // registered from the current step.
        if (inc && !dec) begin
            nextPeriod = (mPeriod - periodDelta < minPeriod) ? minPeriod : mPeriod - periodDelta;
        end else if (dec && !inc) begin
            nextPeriod = (mPeriod + periodDelta > maxPeriod) ? maxPeriod : mPeriod + periodDelta;
        end
        if (!s) begin
            mRun = 1'b0;
            mStep = 0;
            mRev = '0;
        end else if (!mStartPrev) begin
            mRun = 1'b1;
            mStep = 1;
            mCount = mPeriod;
        end else if (mCount == 1) begin
            if (mStep == 6) begin
                mRev = mRev + 1'b1; // step 6 to 7 closes a revolution.
            end
            mStep = (mStep == 12) ? 1 : mStep + 1;
            mCount = mPeriod;
        end else begin
            mCount = mCount - 1;
        end
        mStartPrev = s;
        mPeriod = nextPeriod;
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // one clock cycle: drive on the falling edge, check before the rising edge.
    task automatic runCycle(input logic s, input logic inc, input logic dec);
        @(negedge clk);
        start = s;
        freqInc = inc;
        freqDec = dec;
        #5;
        checkStrobe(testName, mRun && s && (mCount == 1), stepStrobe);
        checkGates(testName, mGates, gates);
        checkRev(testName, mRev, revCount);
        if (dut.uProps.failCount != 0) begin
            failNow($sformatf("an assertion on the gates or step indices fired in test %s",
                testName));
        end
        lastStrobe = stepStrobe;
        advanceModel(s, inc, dec);
    endtask

    task automatic randomPulses(output logic inc, output logic dec);
        logic [31:0] r;
        r = $random(seed);
        inc = (r[4:0] == 5'd0) || (r[4:0] == 5'd2); // code 2 sends both at once.
        dec = (r[4:0] == 5'd1) || (r[4:0] == 5'd2);
    endtask

    task automatic waitStrobe(input int limit);
        int   waited;
        logic inc;
        logic dec;
        waited = 0;
        lastStrobe = 1'b0;
        while (!lastStrobe) begin
            if (waited > limit) begin
                failNow($sformatf("no step strobe within %0d cycles in test %s", limit, testName));
            end
            randomPulses(inc, dec);
            runCycle(1'b1, inc, dec);
            waited++;
        end
    endtask

    initial begin
        #2000000;
        failNow("simulation timed out");
    end

    initial begin
        logic [31:0] r;
        int          runLen;
        logic        inc;
        logic        dec;
        seed = 13858;
        arstN = 1'b0;
        start = 1'b0;
        freqInc = 1'b0;
        freqDec = 1'b0;
        lastStrobe = 1'b0;
        testName = "reset";
        mPeriod = initPeriod;
        mStep = 0;
        mCount = 0;
        mRev = '0;
        mRun = 1'b0;
        mStartPrev = 1'b0;
        mGates = '0;
        repeat (16) @(negedge clk);
        arstN = 1'b1;

        testName = "idle";
        repeat (30) begin
            randomPulses(inc, dec);
            runCycle(1'b0, inc, dec);
        end

        testName = "spacing";
        runCycle(1'b1, 1'b0, 1'b0);
        repeat (30) waitStrobe(maxPeriod + 2);

        testName = "clamp";
        repeat (6) runCycle(1'b1, 1'b1, 1'b0); // drives the period past the lower limit.
        repeat (3) waitStrobe(maxPeriod + 2);
        repeat (6) runCycle(1'b1, 1'b0, 1'b1);
        runCycle(1'b1, 1'b1, 1'b1);
        repeat (3) waitStrobe(maxPeriod + 2);

        testName = "stop";
        repeat (5) runCycle(1'b0, 1'b0, 1'b0);

        testName = "restart";
        runCycle(1'b1, 1'b0, 1'b0);
        repeat (14) waitStrobe(maxPeriod + 2);

        testName = "random";
        repeat (25) begin
            r = $random(seed);
            runLen = 20 + (r % 180);
            repeat (runLen) begin
                randomPulses(inc, dec);
                runCycle(1'b1, inc, dec);
            end
            r = $random(seed);
            runLen = 1 + (r % 6);
            repeat (runLen) begin
                randomPulses(inc, dec);
                runCycle(1'b0, inc, dec);
            end
        end
        runCycle(1'b0, 1'b0, 1'b0);
        @(negedge clk); // lets the assertions see the last rising edge.

        if (dut.uProps.failCount == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "assertion failures were recorded");
        end
    end

endmodule
